/* files.f */
src/fpu_prenorm_pkg.sv
src/special_case_resolver.sv
src/operand_orderer.sv
src/prenorm_stage_reg.sv
src/mantissa_aligner.sv
src/fp_prenorm_top.sv
tests/fp_prenorm_tb.sv

/* src/fp_prenorm_top.sv */
/*
 * Top of the adder pre-normalization front end. Operands sampled with
 * in_valid come out two clocks later with out_valid; one new operation
 * may enter every cycle.
 */
`timescale 1ns/100ps
`default_nettype none

module fp_prenorm_top
(
	input  logic                      clk,
	input  logic                      rst,	// Sync, active high
	input  logic                      in_valid,	// One strobe per operation
	input  fpu_prenorm_pkg::fp_word_t op_a,
	input  fpu_prenorm_pkg::fp_word_t op_b,
	input  logic                      add_sub,	// 1 = a - b
	output logic                      out_valid,
	output fpu_prenorm_pkg::prenorm_t result,
	output fpu_prenorm_pkg::fp_word_t special_result,
	output logic                      normal_path
);

	import fpu_prenorm_pkg::*;

	stage_t entry;	// Producer output, packed here
	stage_t stage;	// Registered entry
	logic   stage_valid;

	// ====================
	// Producer
	// ====================
	special_case_resolver special_case_resolver_i
	(
		.op_a           (op_a),
		.op_b           (op_b),
		.add_sub        (add_sub),
		.special_result (entry.special_result),
		.normal_path    (entry.normal_path)
	);

	operand_orderer operand_orderer_i
	(
		.op_a    (op_a),
		.op_b    (op_b),
		.add_sub (add_sub),
		.ord     (entry.ord)
	);

	// ====================
	// Buffer and consumer
	// ====================
	prenorm_stage_reg prenorm_stage_reg_i
	(
		.clk         (clk),
		.rst         (rst),
		.in_valid    (in_valid),
		.entry       (entry),
		.stage_valid (stage_valid),
		.stage       (stage)
	);

	mantissa_aligner mantissa_aligner_i
	(
		.clk            (clk),
		.rst            (rst),
		.stage_valid    (stage_valid),
		.stage          (stage),
		.out_valid      (out_valid),
		.result         (result),
		.special_result (special_result),
		.normal_path    (normal_path)
	);

endmodule

`default_nettype wire

/* src/fpu_prenorm_pkg.sv */
/*
 * Shared widths, vector types, operand class and bundles for the
 * single-precision pre-normalization pipeline.
 * Imported by every RTL block and by the testbench.
 */
`default_nettype none

package fpu_prenorm_pkg;

	// ====================
	// Widths
	// ====================
	localparam int EXP_W = 8;	// Biased exponent
	localparam int FRA_W = 23;	// Stored fraction, no hidden bit
	localparam int MAN_W = FRA_W + 1;	// Hidden one on top
	localparam int FMT_W = 1 + EXP_W + FRA_W;	// Sign, exponent, fraction

	// Barrel shifter levels, 1/2/4/8/16
	localparam int SHIFT_LVL = $clog2(MAN_W);

	// ====================
	// Vector types
	// ====================
	typedef logic [EXP_W-1:0] exp_t;	// Exponent, also exponent difference
	typedef logic [FRA_W-1:0] fra_t;
	typedef logic [MAN_W-1:0] man_t;	// 1.fraction

	// Operand class as a two-bit code
	typedef enum logic [1:0]
	{
		FP_ZERO   = 2'b00,
		FP_NAN    = 2'b01,
		FP_INF    = 2'b10,
		FP_NORMAL = 2'b11
	} fp_class_e;

	// ====================
	// Bundles
	// ====================
	// IEEE single word, MSB first
	typedef struct packed
	{
		logic sign;
		exp_t exp;
		fra_t fra;
	} fp_word_t;

	// Operands after magnitude ordering
	typedef struct packed
	{
		logic sign;	// Result sign
		logic sign_x;	// Raw sign, larger operand
		logic sign_y;	// Raw sign, smaller operand
		exp_t exp;	// Larger exponent
		man_t man_x;	// Larger mantissa with hidden one
		fra_t fra_y;	// Smaller fraction, still unaligned
		exp_t shift;	// Exponent difference
	} order_t;

	// One pipeline entry between producer and aligner
	typedef struct packed
	{
		order_t   ord;
		fp_word_t special_result;
		logic     normal_path;	// Both operands normal
	} stage_t;

	// Aligned operands handed to the adder proper
	typedef struct packed
	{
		logic sign;
		logic sign_x;
		logic sign_y;
		exp_t exp;
		man_t man_x;
		man_t man_y;	// Shifted right by the exponent difference
	} prenorm_t;

endpackage

`default_nettype wire

/* src/mantissa_aligner.sv */
/*
 * Right-aligns the smaller mantissa by the exponent difference with a
 * five-level barrel shifter, then registers the aligned operands with
 * the special result and flag carried along from the stage register.
 */
`timescale 1ns/100ps
`default_nettype none

module mantissa_aligner
(
	input  logic                      clk,
	input  logic                      rst,	// Sync, active high
	input  logic                      stage_valid,
	input  fpu_prenorm_pkg::stage_t   stage,
	output logic                      out_valid,
	output fpu_prenorm_pkg::prenorm_t result,
	output fpu_prenorm_pkg::fp_word_t special_result,
	output logic                      normal_path
);

	import fpu_prenorm_pkg::*;

	man_t     lvl [0:SHIFT_LVL];	// lvl[0] input, last entry fully shifted
	logic     shift_ovf;	// Difference of 32 or more
	prenorm_t aligned;

	// ====================
	// Barrel shifter
	// ====================
	// Upper difference bits set means everything falls off the end
	assign shift_ovf = |stage.ord.shift[EXP_W-1:SHIFT_LVL];
	assign lvl[0]    = shift_ovf ? '0 : {1'b1, stage.ord.fra_y};

	// Level i shifts by 2**i, zero fill from the top
	for (genvar i = 0; i < SHIFT_LVL; i++)
	begin : g_lvl
		assign lvl[i+1] = stage.ord.shift[i] ? (lvl[i] >> (2**i)) : lvl[i];
	end

	assign aligned.sign   = stage.ord.sign;
	assign aligned.sign_x = stage.ord.sign_x;
	assign aligned.sign_y = stage.ord.sign_y;
	assign aligned.exp    = stage.ord.exp;
	assign aligned.man_x  = stage.ord.man_x;	// Larger one is never shifted
	assign aligned.man_y  = lvl[SHIFT_LVL];

	// ====================
	// Output register
	// ====================
	always_ff @(posedge clk)
	begin
		if (rst)
			out_valid <= 1'b0;
		else
			out_valid <= stage_valid;	// Second and last cycle of latency
	end

	// Data rides along unreset
	always_ff @(posedge clk)
	begin
		result         <= aligned;
		special_result <= stage.special_result;
		normal_path    <= stage.normal_path;
	end

endmodule

`default_nettype wire

/* src/operand_orderer.sv */
/*
 * Orders the two operands by magnitude, picks the result sign and
 * forms the exponent difference. Combinational, runs next to the
 * special-case resolver and feeds the same pipeline entry.
 */
`timescale 1ns/100ps
`default_nettype none

module operand_orderer
(
	input  fpu_prenorm_pkg::fp_word_t op_a,
	input  fpu_prenorm_pkg::fp_word_t op_b,
	input  logic                      add_sub,	// 1 = subtract
	output fpu_prenorm_pkg::order_t   ord
);

	import fpu_prenorm_pkg::*;

	logic     exp_b_gt;	// b exponent strictly larger
	logic     exp_eq;
	logic     fra_b_gt;	// b fraction strictly larger
	logic     swap;
	fp_word_t op_x;	// Larger magnitude
	fp_word_t op_y;	// Smaller magnitude
	man_t     man_x;
	exp_t     exp_diff;
	logic     res_sign;

	// ====================
	// Magnitude compare
	// ====================
	assign exp_b_gt = op_b.exp > op_a.exp;
	assign exp_eq   = op_b.exp == op_a.exp;
	assign fra_b_gt = op_b.fra > op_a.fra;

	// Ties stay unswapped so a is kept as x
	assign swap = exp_b_gt || (exp_eq && fra_b_gt);

	// ====================
	// Routing
	// ====================
	assign op_x = swap ? op_b : op_a;
	assign op_y = swap ? op_a : op_b;

	assign man_x    = {1'b1, op_x.fra};	// Hidden one, normals only matter
	assign exp_diff = op_x.exp - op_y.exp;	// Never negative after the swap

	// Sign follows the larger operand, b's sign flips under subtract
	always_comb
	begin
		if (swap)
			res_sign = op_b.sign ^ add_sub;
		else
			res_sign = op_a.sign;
	end

	assign ord.sign   = res_sign;
	assign ord.sign_x = op_x.sign;	// Raw, no subtract flip
	assign ord.sign_y = op_y.sign;
	assign ord.exp    = op_x.exp;
	assign ord.man_x  = man_x;
	assign ord.fra_y  = op_y.fra;	// Hidden one added in the aligner
	assign ord.shift  = exp_diff;

endmodule

`default_nettype wire

/* src/prenorm_stage_reg.sv */
/*
 * Pipeline register between the classify/order logic and the shifter.
 * Captures one entry per clock; only the valid bit sees reset.
 */
`timescale 1ns/100ps
`default_nettype none

module prenorm_stage_reg
(
	input  logic                    clk,
	input  logic                    rst,	// Sync, active high
	input  logic                    in_valid,
	input  fpu_prenorm_pkg::stage_t entry,
	output logic                    stage_valid,
	output fpu_prenorm_pkg::stage_t stage
);

	// ====================
	// Valid bit
	// ====================
	always_ff @(posedge clk)
	begin
		if (rst)
			stage_valid <= 1'b0;
		else
			stage_valid <= in_valid;	// One entry per strobe
	end

	// ====================
	// Payload
	// ====================
	// Loaded every cycle, contents ignored while stage_valid is low
	always_ff @(posedge clk)
	begin
		stage <= entry;
	end

endmodule

`default_nettype wire

/* src/special_case_resolver.sv */
/*
 * Classifies both operands and picks the special-case result by the
 * fixed priority list. Purely combinational; normal_path tells the
 * later stages whether the aligned mantissas are meaningful at all.
 */
`timescale 1ns/100ps
`default_nettype none

module special_case_resolver
(
	input  fpu_prenorm_pkg::fp_word_t op_a,
	input  fpu_prenorm_pkg::fp_word_t op_b,
	input  logic                      add_sub,	// 1 = subtract
	output fpu_prenorm_pkg::fp_word_t special_result,
	output logic                      normal_path
);

	import fpu_prenorm_pkg::*;

	fp_class_e class_a;
	fp_class_e class_b;
	fp_word_t  b_seen;	// op_b as the adder sees it
	logic      both_inf;
	logic      inf_sign;	// Sign for opposite infinities

	// ====================
	// Classification
	// ====================
	// Exponent zero counts as zero whatever the fraction holds
	function automatic fp_class_e classify(input fp_word_t op);
		fp_class_e cls;
		if (op.exp == '0)
			cls = FP_ZERO;
		else if (op.exp != '1)
			cls = FP_NORMAL;
		else if (op.fra == '0)
			cls = FP_INF;
		else
			cls = FP_NAN;	// All ones, fraction nonzero
		return cls;
	endfunction

	assign class_a = classify(op_a);
	assign class_b = classify(op_b);

	// Subtraction flips the sign bit of b only
	assign b_seen = op_b ^ {add_sub, {(FMT_W-1){1'b0}}};

	assign both_inf = (class_a == FP_INF) && (class_b == FP_INF);
	assign inf_sign = op_a.sign && !op_b.sign && add_sub;	// -inf - (+inf)

	// ====================
	// Priority list
	// ====================
	always_comb
	begin
		special_result = '0;	// Rule 9, nothing special
		if (class_a == FP_ZERO)
			special_result = b_seen;	// 0 +/- b
		else if (class_b == FP_ZERO)
			special_result = op_a;	// a +/- 0
		else if ((class_a == FP_NORMAL) && (class_b == FP_INF))
			special_result = b_seen;
		else if ((class_a == FP_INF) && (class_b == FP_NORMAL))
			special_result = op_a;
		else if (both_inf && (op_a.sign == op_b.sign))
			special_result = op_a;
		else if (both_inf)
		begin
			// Opposite infinities keep a's bit pattern
			special_result.sign = inf_sign;
			special_result.exp  = op_a.exp;
			special_result.fra  = op_a.fra;
		end
		else if (class_a == FP_NAN)
			special_result = op_a;	// NaN in a wins
		else if (class_b == FP_NAN)
			special_result = op_b;	// b passed raw, sign not flipped
	end

	// Normal datapath only when neither side is special
	assign normal_path = (class_a == FP_NORMAL) && (class_b == FP_NORMAL);

endmodule

`default_nettype wire

/* tests/fp_prenorm_tb.sv */
/*
 * Table-driven testbench for the adder pre-normalization front end.
 * Operations go in back to back, one per clock. A negedge checker pops
 * the expected values and verifies data and the two-cycle latency.
 */
`timescale 1ns/100ps
`default_nettype none

module fp_prenorm_tb;

	import fpu_prenorm_pkg::*;

	localparam int CLK_HALF    = 50;	// 100 ns period
	localparam int LATENCY     = 2;	// Launch edge to out_valid edge
	localparam int DRAIN_LIMIT = 20;	// Cycles allowed to empty the pipe

	// One table row
	typedef struct packed
	{
		fp_word_t a;
		fp_word_t b;
		logic     sub;
		fp_word_t spec;	// Expected special_result
		logic     norm;	// Expected normal_path
		prenorm_t pre;	// Checked only when norm is set
	} case_t;

	logic      clk;
	logic      rst;
	logic      in_valid;
	fp_word_t  op_a;
	fp_word_t  op_b;
	logic      add_sub;
	logic      out_valid;
	prenorm_t  result;
	fp_word_t  special_result;
	logic      normal_path;

	case_t cases[$];
	int    pend_idx[$];	// Table index per operation in flight
	int    pend_edge[$];	// Edge it was driven after
	int    cyc = 0;
	int    word_errs = 0;
	int    pre_errs = 0;
	int    flag_errs = 0;
	int    timing_errs = 0;
	int    n_checked = 0;

	fp_prenorm_top fp_prenorm_top_i
	(
		.clk            (clk),
		.rst            (rst),
		.in_valid       (in_valid),
		.op_a           (op_a),
		.op_b           (op_b),
		.add_sub        (add_sub),
		.out_valid      (out_valid),
		.result         (result),
		.special_result (special_result),
		.normal_path    (normal_path)
	);

	initial
		clk = 1'b0;
	always #CLK_HALF clk = ~clk;

	always @(posedge clk)
		cyc <= cyc + 1;	// Edge count

	// ====================
	// Table
	// ====================
	function automatic prenorm_t make_prenorm(input logic sign, input logic sign_x,
		input logic sign_y, input exp_t exp, input man_t man_x, input man_t man_y);
		prenorm_t p;
		p.sign   = sign;
		p.sign_x = sign_x;
		p.sign_y = sign_y;
		p.exp    = exp;
		p.man_x  = man_x;
		p.man_y  = man_y;
		return p;
	endfunction

	task automatic add_case(input fp_word_t a, input fp_word_t b, input logic sub,
		input fp_word_t spec, input logic norm, input prenorm_t pre);
		case_t c;
		c.a    = a;
		c.b    = b;
		c.sub  = sub;
		c.spec = spec;
		c.norm = norm;
		c.pre  = pre;
		cases.push_back(c);
	endtask

	task automatic fill_table;
		// Zeros, exponent zero wins over the fraction
		add_case(32'h0000_0000, 32'h4020_0000, 1'b0, 32'h4020_0000, 1'b0, '0);
		add_case(32'h0000_0000, 32'h4020_0000, 1'b1, 32'hC020_0000, 1'b0, '0);	// Flipped b
		add_case(32'hC092_3456, 32'h0000_0000, 1'b1, 32'hC092_3456, 1'b0, '0);
		add_case(32'h007F_FFFF, 32'hC800_0001, 1'b1, 32'h4800_0001, 1'b0, '0);
		add_case(32'hBF80_0000, 32'h0000_0055, 1'b0, 32'hBF80_0000, 1'b0, '0);
		add_case(32'h8000_0000, 32'h8000_0000, 1'b1, 32'h0000_0000, 1'b0, '0);
		// Infinities
		add_case(32'h4000_0000, 32'h7F80_0000, 1'b1, 32'hFF80_0000, 1'b0, '0);	// x - inf
		add_case(32'h4000_0000, 32'hFF80_0000, 1'b0, 32'hFF80_0000, 1'b0, '0);
		add_case(32'h7F80_0000, 32'hC280_0001, 1'b1, 32'h7F80_0000, 1'b0, '0);
		add_case(32'h7F80_0000, 32'h7F80_0000, 1'b0, 32'h7F80_0000, 1'b0, '0);
		add_case(32'hFF80_0000, 32'hFF80_0000, 1'b1, 32'hFF80_0000, 1'b0, '0);
		add_case(32'h7F80_0000, 32'hFF80_0000, 1'b0, 32'h7F80_0000, 1'b0, '0);
		add_case(32'hFF80_0000, 32'h7F80_0000, 1'b0, 32'h7F80_0000, 1'b0, '0);
		add_case(32'hFF80_0000, 32'h7F80_0000, 1'b1, 32'hFF80_0000, 1'b0, '0);	// Only sign 1
		add_case(32'h7F80_0000, 32'hFF80_0000, 1'b1, 32'h7F80_0000, 1'b0, '0);
		// NaN in either slot
		add_case(32'h7FC0_0000, 32'hC000_0000, 1'b0, 32'h7FC0_0000, 1'b0, '0);
		add_case(32'h4000_0000, 32'hFF80_0001, 1'b1, 32'hFF80_0001, 1'b0, '0);	// b raw
		add_case(32'hFFFF_FFFF, 32'h7F80_0000, 1'b1, 32'hFFFF_FFFF, 1'b0, '0);
		add_case(32'h7F80_0000, 32'h7F80_0100, 1'b0, 32'h7F80_0100, 1'b0, '0);
		// ====================
		// Ordering and sign
		// ====================
		add_case(32'h4010_0000, 32'hC120_0000, 1'b0, '0, 1'b1,
			make_prenorm(1'b1, 1'b1, 1'b0, 8'h82, 24'hA0_0000, 24'h24_0000));
		add_case(32'h4010_0000, 32'hC120_0000, 1'b1, '0, 1'b1,
			make_prenorm(1'b0, 1'b1, 1'b0, 8'h82, 24'hA0_0000, 24'h24_0000));
		add_case(32'hC800_0010, 32'h4800_0020, 1'b0, '0, 1'b1,	// Fraction decides
			make_prenorm(1'b0, 1'b0, 1'b1, 8'h90, 24'h80_0020, 24'h80_0010));
		add_case(32'hC800_0010, 32'h4800_0020, 1'b1, '0, 1'b1,
			make_prenorm(1'b1, 1'b0, 1'b1, 8'h90, 24'h80_0020, 24'h80_0010));
		add_case(32'hC434_5678, 32'h4434_5678, 1'b0, '0, 1'b1,	// Tie, no swap
			make_prenorm(1'b1, 1'b1, 1'b0, 8'h88, 24'hB4_5678, 24'hB4_5678));
		add_case(32'hC434_5678, 32'h4434_5678, 1'b1, '0, 1'b1,
			make_prenorm(1'b1, 1'b1, 1'b0, 8'h88, 24'hB4_5678, 24'hB4_5678));
		add_case(32'h4280_0000, 32'hC27F_FFFF, 1'b1, '0, 1'b1,
			make_prenorm(1'b0, 1'b0, 1'b1, 8'h85, 24'h80_0000, 24'h7F_FFFF));
		// Alignment of 1.5A5A5A by 0/1/7/16/23/24/31/64
		add_case(32'h407F_FFFF, 32'h405A_5A5A, 1'b0, '0, 1'b1,
			make_prenorm(1'b0, 1'b0, 1'b0, 8'h80, 24'hFF_FFFF, 24'hDA_5A5A));
		add_case(32'h4080_0000, 32'h405A_5A5A, 1'b0, '0, 1'b1,
			make_prenorm(1'b0, 1'b0, 1'b0, 8'h81, 24'h80_0000, 24'h6D_2D2D));
		add_case(32'h4380_0000, 32'h405A_5A5A, 1'b0, '0, 1'b1,
			make_prenorm(1'b0, 1'b0, 1'b0, 8'h87, 24'h80_0000, 24'h01_B4B4));
		add_case(32'h4800_0000, 32'h405A_5A5A, 1'b0, '0, 1'b1,
			make_prenorm(1'b0, 1'b0, 1'b0, 8'h90, 24'h80_0000, 24'h00_00DA));
		add_case(32'h4B80_0000, 32'h405A_5A5A, 1'b0, '0, 1'b1,
			make_prenorm(1'b0, 1'b0, 1'b0, 8'h97, 24'h80_0000, 24'h00_0001));
		add_case(32'h4C00_0000, 32'h405A_5A5A, 1'b0, '0, 1'b1,
			make_prenorm(1'b0, 1'b0, 1'b0, 8'h98, 24'h80_0000, 24'h00_0000));
		add_case(32'h4F80_0000, 32'h405A_5A5A, 1'b0, '0, 1'b1,
			make_prenorm(1'b0, 1'b0, 1'b0, 8'h9F, 24'h80_0000, 24'h00_0000));
		add_case(32'h6000_0000, 32'h405A_5A5A, 1'b0, '0, 1'b1,
			make_prenorm(1'b0, 1'b0, 1'b0, 8'hC0, 24'h80_0000, 24'h00_0000));
		add_case(32'h405A_5A5A, 32'hD400_0000, 1'b1, '0, 1'b1,	// Swap, shift 40
			make_prenorm(1'b0, 1'b1, 1'b0, 8'hA8, 24'h80_0000, 24'h00_0000));
	endtask

	// ====================
	// Compare tasks
	// ====================
	task automatic check_word(input string what, input fp_word_t got, input fp_word_t want);
		if (got !== want)
		begin
			word_errs++;
			$display("Error at %0t: %s is %h, expected %h", $time, what, got, want);
		end
	endtask

	task automatic check_prenorm(input string what, input prenorm_t got, input prenorm_t want);
		if (got !== want)
		begin
			pre_errs++;
			$display("Error at %0t: %s is %h, expected %h", $time, what, got, want);
		end
	endtask

	task automatic check_flag(input string what, input logic got, input logic want);
		if (got !== want)
		begin
			flag_errs++;
			$display("Error at %0t: %s is %b, expected %b", $time, what, got, want);
		end
	endtask

	// Outputs are registered, so the falling edge sees them settled
	always @(negedge clk)
	begin
		int    idx;
		int    edge_in;
		case_t c;
		if (!rst && out_valid)
		begin
			if (pend_idx.size() == 0)
			begin
				timing_errs++;
				$display("Unexpected out_valid at %0t with no operation in flight", $time);
			end
			else
			begin
				idx     = pend_idx.pop_front();
				edge_in = pend_edge.pop_front();
				c       = cases[idx];
				if (cyc - edge_in != LATENCY)
				begin
					timing_errs++;
					$display("Error at %0t: case %0d took %0d cycles, expected %0d",
						$time, idx, cyc - edge_in, LATENCY);
				end
				check_word($sformatf("case %0d special_result", idx), special_result, c.spec);
				check_flag($sformatf("case %0d normal_path", idx), normal_path, c.norm);
				if (c.norm)	// Aligned data only means something here
					check_prenorm($sformatf("case %0d result", idx), result, c.pre);
				n_checked++;
			end
		end
	end

	// ====================
	// Stimulus
	// ====================
	initial
	begin
		int waited;
		int total;
		rst      = 1'b1;
		in_valid = 1'b0;
		op_a     = '0;
		op_b     = '0;
		add_sub  = 1'b0;
		fill_table();
		repeat (3) @(posedge clk);
		#1 rst = 1'b0;
		repeat (2) @(posedge clk);	// Idle, out_valid must stay low

		// Back to back, one per clock
		for (int i = 0; i < cases.size(); i++)
		begin
			@(posedge clk);
			#1;
			in_valid = 1'b1;
			op_a     = cases[i].a;
			op_b     = cases[i].b;
			add_sub  = cases[i].sub;
			pend_idx.push_back(i);
			pend_edge.push_back(cyc);	// Launch edge of this operation
		end
		@(posedge clk);
		#1 in_valid = 1'b0;

		waited = 0;
		while (pend_idx.size() != 0 && waited < DRAIN_LIMIT)
		begin
			@(posedge clk);
			waited++;
		end

		if (pend_idx.size() != 0)
		begin
			$display("Timed out waiting for out_valid, %0d operations never came out",
				pend_idx.size());
			$display("Some tests failed");
			$finish;
		end
		else
		begin
			repeat (3) @(posedge clk);	// Catch any stray out_valid
			total = word_errs + pre_errs + flag_errs + timing_errs;
			$display("Checked %0d of %0d: %0d word, %0d prenorm, %0d flag, %0d timing errors",
				n_checked, cases.size(), word_errs, pre_errs, flag_errs, timing_errs);
			if (total == 0 && n_checked == cases.size())
				$display("All tests passed");
			else
				$display("Some tests failed");
			$finish;
		end
	end

endmodule

`default_nettype wire
